//--- flist.f
+incdir+hw
hw/l2c_pkg.sv
hw/l2c_req_buf.sv
hw/l2c_tag_array.sv
hw/l2c_data_array.sv
hw/l2c_plru.sv
hw/l2c_fsm_main.sv
hw/l2c_top.sv
testbench/tb_l2c_top.sv

//--- hw/l2c_consts.svh
`ifndef L2C_CONSTS_SVH
`define L2C_CONSTS_SVH

////////////////////////////////////////////////////////////
// l2 cache geometry
////////////////////////////////////////////////////////////

`define L2C_WAYS        4
`define L2C_INDEX_W     4   // 16 sets
`define L2C_OFFSET_W    4   // byte offset inside a line
`define L2C_LINE_WORDS  4   // 32-bit words per line

// whatever is left of the 32-bit address
`define L2C_TAG_W       (32 - `L2C_INDEX_W - `L2C_OFFSET_W)

`endif

//--- hw/l2c_data_array.sv
`timescale 1ns/10ps
`include "l2c_consts.svh"

module l2c_data_array import l2c_pkg::*; (
    input  logic       clk,
    input  index_t     index,
    input  logic [1:0] word_sel,
    input  way_idx_t   sel_way,
    input  logic       word_we,
    input  logic       fill_we,
    input  word_t      wdata,
    input  line_t      fill_line,
    output word_t      rd_word,
    output line_t      rd_line
);

    localparam int SETS = 1 << `L2C_INDEX_W;

    line_t lines [SETS][`L2C_WAYS];
    line_t src_line;

    // whole line on refill, single word on a store
    always_ff @(posedge clk) begin
        if (fill_we) begin
            lines[index][sel_way] <= fill_line;
        end else if (word_we) begin
            lines[index][sel_way][32 * word_sel +: 32] <= wdata;
        end
    end

    assign rd_line = lines[index][sel_way];   // also the writeback victim

    // refill data is forwarded so a read miss can answer in the fill cycle
    assign src_line = fill_we ? fill_line : rd_line;
    assign rd_word  = src_line[32 * word_sel +: 32];

endmodule

//--- hw/l2c_fsm_main.sv
`timescale 1ns/10ps
`include "l2c_consts.svh"

module l2c_fsm_main import l2c_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      icache_req,
    input  logic      dcache_req,
    output logic      icache_addr_ok,
    output logic      icache_data_ok,
    output logic      dcache_addr_ok,
    output logic      dcache_data_ok,
    input  l2c_req_t  cur_req,
    input  way_mask_t hit,
    input  way_idx_t  victim_way,
    input  logic      victim_dirty,
    output logic      mem_req_r,
    output logic      mem_req_w,
    output logic      mem_rdy,
    input  logic      mem_addr_ok_r,
    input  logic      mem_addr_ok_w,
    input  logic      mem_data_ok,
    output logic      buf_we,
    output logic      tag_we,
    output logic      dirty_set,
    output logic      dirty_clr,
    output logic      word_we,
    output logic      fill_we,
    output logic      use_we,
    output way_idx_t  sel_way,
    output way_idx_t  use_way
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        check_dirty,
        writeback,
        refill_req,
        refill_wait,
        merge_write
    } state_t;

    state_t   state;
    state_t   next_state;
    way_idx_t hit_way;
    way_idx_t victim_reg;   // way being replaced on a miss
    logic     any_hit;

    assign any_hit = |hit;

    always_comb begin
        hit_way = '0;
        for (int w = `L2C_WAYS - 1; w >= 0; w--) begin
            if (hit[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= idle;
            victim_reg <= '0;
        end else begin
            state <= next_state;
            if (state == check_dirty) begin
                victim_reg <= victim_way;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            idle:        if (icache_req || dcache_req) next_state = lookup;
            lookup:      next_state = any_hit ? idle : check_dirty;
            check_dirty: next_state = victim_dirty ? writeback : refill_req;
            writeback:   if (mem_addr_ok_w) next_state = refill_req;
            refill_req:  if (mem_addr_ok_r) next_state = refill_wait;
            refill_wait: if (mem_data_ok) next_state = cur_req.wr ? merge_write : idle;
            merge_write: next_state = idle;
            default:     next_state = idle;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        icache_addr_ok = 1'b0;
        icache_data_ok = 1'b0;
        dcache_addr_ok = 1'b0;
        dcache_data_ok = 1'b0;
        mem_req_r      = 1'b0;
        mem_req_w      = 1'b0;
        mem_rdy        = 1'b0;
        buf_we         = 1'b0;
        tag_we         = 1'b0;
        dirty_set      = 1'b0;
        dirty_clr      = 1'b0;
        word_we        = 1'b0;
        fill_we        = 1'b0;
        use_we         = 1'b0;
        sel_way        = victim_reg;
        use_way        = victim_reg;
        case (state)
            idle: begin
                buf_we = icache_req | dcache_req;
                if (dcache_req) begin
                    dcache_addr_ok = 1'b1;   // dcache first
                end else if (icache_req) begin
                    icache_addr_ok = 1'b1;
                end
            end
            lookup: begin
                sel_way = hit_way;
                use_way = hit_way;
                if (any_hit) begin
                    use_we = 1'b1;
                    if (cur_req.wr) begin
                        word_we   = 1'b1;
                        dirty_set = 1'b1;
                    end else if (cur_req.is_dcache) begin
                        dcache_data_ok = 1'b1;
                    end else begin
                        icache_data_ok = 1'b1;
                    end
                end
            end
            check_dirty: sel_way = victim_way;    // peek dirty bit of the pick
            writeback:   mem_req_w = 1'b1;
            refill_req:  mem_req_r = 1'b1;
            refill_wait: begin
                mem_rdy = 1'b1;
                if (mem_data_ok) begin
                    fill_we = 1'b1;
                    tag_we  = 1'b1;
                    if (!cur_req.wr) begin
                        dirty_clr      = 1'b1;    // clean line after refill
                        use_we         = 1'b1;
                        dcache_data_ok = cur_req.is_dcache;
                        icache_data_ok = ~cur_req.is_dcache;
                    end
                end
            end
            merge_write: begin
                word_we   = 1'b1;
                dirty_set = 1'b1;
                use_we    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/l2c_pkg.sv
`include "l2c_consts.svh"

package l2c_pkg;

    typedef logic [31:0]                     addr_t;     // byte address
    typedef logic [31:0]                     word_t;
    typedef logic [32*`L2C_LINE_WORDS-1:0]   line_t;
    typedef logic [`L2C_TAG_W-1:0]           tag_t;
    typedef logic [`L2C_INDEX_W-1:0]         index_t;
    typedef logic [$clog2(`L2C_WAYS)-1:0]    way_idx_t;
    typedef logic [`L2C_WAYS-1:0]            way_mask_t; // one bit per way

    // request as held by the request buffer
    typedef struct packed {
        logic  is_dcache;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } l2c_req_t;

    // victim line going out to memory
    typedef struct packed {
        addr_t addr;
        line_t line;
    } mem_wr_t;

endpackage

//--- hw/l2c_plru.sv
`timescale 1ns/10ps
`include "l2c_consts.svh"

module l2c_plru import l2c_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  index_t    index,
    input  logic      use_we,
    input  way_idx_t  use_way,
    input  way_mask_t valid_mask,
    output way_idx_t  victim_way
);

    localparam int SETS = 1 << `L2C_INDEX_W;

    // [0] root, [1] picks within ways 0/1, [2] within ways 2/3
    logic [2:0] tree [SETS];
    logic [2:0] cur;

    assign cur = tree[index];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (use_we) begin
            tree[index][0] <= ~use_way[1];      // point at the other half
            if (use_way[1]) begin
                tree[index][2] <= ~use_way[0];
            end else begin
                tree[index][1] <= ~use_way[0];
            end
        end
    end

    // empty ways are filled first, lowest one wins
    always_comb begin
        victim_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
        for (int w = `L2C_WAYS - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                victim_way = way_idx_t'(w);
            end
        end
    end

endmodule

//--- hw/l2c_req_buf.sv
`timescale 1ns/10ps

module l2c_req_buf import l2c_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     buf_we,
    input  logic     icache_req,
    input  logic     dcache_req,
    input  logic     dcache_wr,
    input  addr_t    icache_addr,
    input  addr_t    dcache_addr,
    input  word_t    dcache_wdata,
    output l2c_req_t cur_req
);

    // data cache has priority over instruction cache
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cur_req <= '0;
        end else if (buf_we) begin
            if (dcache_req) begin
                cur_req.is_dcache <= 1'b1;
                cur_req.wr        <= dcache_wr;
                cur_req.addr      <= dcache_addr;
                cur_req.wdata     <= dcache_wdata;
            end else if (icache_req) begin
                cur_req.is_dcache <= 1'b0;
                cur_req.wr        <= 1'b0;      // icache only reads
                cur_req.addr      <= icache_addr;
                cur_req.wdata     <= '0;
            end
        end
    end

endmodule

//--- hw/l2c_tag_array.sv
`timescale 1ns/10ps
`include "l2c_consts.svh"

module l2c_tag_array import l2c_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  addr_t     addr,
    output way_mask_t hit,
    output way_mask_t valid_mask,
    input  way_idx_t  sel_way,
    input  logic      tag_we,
    input  logic      dirty_set,
    input  logic      dirty_clr,
    output logic      victim_dirty,
    output tag_t      victim_tag
);

    localparam int SETS = 1 << `L2C_INDEX_W;

    tag_t      tags  [SETS][`L2C_WAYS];
    way_mask_t valid [SETS];
    way_mask_t dirty [SETS];

    index_t index;
    tag_t   tag;

    assign index = addr[`L2C_OFFSET_W +: `L2C_INDEX_W];
    assign tag   = addr[31 -: `L2C_TAG_W];

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[index][sel_way] <= tag;   // refill
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (tag_we) begin
                valid[index][sel_way] <= 1'b1;
            end
            if (dirty_set) begin
                dirty[index][sel_way] <= 1'b1;
            end else if (dirty_clr) begin
                dirty[index][sel_way] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // lookup of the addressed set
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < `L2C_WAYS; w++) begin
            hit[w] = valid[index][w] && (tags[index][w] == tag);
        end
    end

    assign valid_mask   = valid[index];
    assign victim_dirty = dirty[index][sel_way] & valid[index][sel_way]; // only a live line needs writeback
    assign victim_tag   = tags[index][sel_way];                          // old tag for writeback addr

endmodule

//--- hw/l2c_top.sv
`timescale 1ns/10ps
`include "l2c_consts.svh"

module l2c_top import l2c_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    // instruction cache
    input  logic    icache_req,
    input  addr_t   icache_addr,
    output logic    icache_addr_ok,
    output logic    icache_data_ok,
    output word_t   icache_rdata,
    // data cache
    input  logic    dcache_req,
    input  logic    dcache_wr,
    input  addr_t   dcache_addr,
    input  word_t   dcache_wdata,
    output logic    dcache_addr_ok,
    output logic    dcache_data_ok,
    output word_t   dcache_rdata,
    // memory
    output logic    mem_req_r,
    output addr_t   mem_raddr,
    input  logic    mem_addr_ok_r,
    output logic    mem_rdy,
    input  logic    mem_data_ok,
    input  line_t   mem_rdata,
    output logic    mem_req_w,
    output mem_wr_t mem_wr,
    input  logic    mem_addr_ok_w
);

    l2c_req_t  cur_req;
    way_mask_t hit;
    way_mask_t valid_mask;
    way_idx_t  sel_way;
    way_idx_t  use_way;
    way_idx_t  victim_way;
    tag_t      victim_tag;
    index_t    index;
    word_t     rd_word;
    line_t     rd_line;
    logic      victim_dirty;
    logic      buf_we;
    logic      tag_we;
    logic      dirty_set;
    logic      dirty_clr;
    logic      word_we;
    logic      fill_we;
    logic      use_we;

    assign index = cur_req.addr[`L2C_OFFSET_W +: `L2C_INDEX_W];

    // line aligned addresses toward memory
    assign mem_raddr   = {cur_req.addr[31:`L2C_OFFSET_W], {`L2C_OFFSET_W{1'b0}}};
    assign mem_wr.addr = {victim_tag, index, {`L2C_OFFSET_W{1'b0}}};
    assign mem_wr.line = rd_line;

    assign icache_rdata = rd_word;
    assign dcache_rdata = rd_word;

    l2c_req_buf u_req_buf (
        .clk, .rstn, .buf_we, .icache_req, .dcache_req, .dcache_wr,
        .icache_addr, .dcache_addr, .dcache_wdata, .cur_req
    );

    l2c_tag_array u_tag_array (
        .clk, .rstn, .addr(cur_req.addr), .hit, .valid_mask, .sel_way,
        .tag_we, .dirty_set, .dirty_clr, .victim_dirty, .victim_tag
    );

    l2c_data_array u_data_array (
        .clk, .index, .word_sel(cur_req.addr[`L2C_OFFSET_W-1:2]), .sel_way,
        .word_we, .fill_we, .wdata(cur_req.wdata), .fill_line(mem_rdata),
        .rd_word, .rd_line
    );

    l2c_plru u_plru (
        .clk, .rstn, .index, .use_we, .use_way, .valid_mask, .victim_way
    );

    l2c_fsm_main u_fsm_main (
        .clk, .rstn, .icache_req, .dcache_req,
        .icache_addr_ok, .icache_data_ok, .dcache_addr_ok, .dcache_data_ok,
        .cur_req, .hit, .victim_way, .victim_dirty,
        .mem_req_r, .mem_req_w, .mem_rdy, .mem_addr_ok_r, .mem_addr_ok_w, .mem_data_ok,
        .buf_we, .tag_we, .dirty_set, .dirty_clr, .word_we, .fill_we, .use_we,
        .sel_way, .use_way
    );

endmodule

//--- run_sim.sh
#!/bin/bash
# build and run the l2 cache testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 -f flist.f --top-module tb_l2c_top \
    && ./obj_dir/Vtb_l2c_top | tee sim.log \
    || { echo "verilator build or run failed"; exit 1; }

grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

//--- testbench/tb_l2c_top.sv
`timescale 1ns/10ps
`include "l2c_consts.svh"

module tb_l2c_top import l2c_pkg::*; ();

    typedef struct packed {
        int    src;     // 0 icache, 1 dcache, 2 both at once
        int    wr;
        addr_t addr;
        word_t wdata;
        word_t exp;
        int    hit;     // 0 miss, 1 hit, 2 either
        addr_t iaddr;   // icache side of a dual request
        word_t iexp;
        int    wb;      // eviction must write back
    } test_t;

    logic    clk = 1'b0;
    logic    rstn;
    logic    icache_req;
    addr_t   icache_addr;
    logic    icache_addr_ok;
    logic    icache_data_ok;
    word_t   icache_rdata;
    logic    dcache_req;
    logic    dcache_wr;
    addr_t   dcache_addr;
    word_t   dcache_wdata;
    logic    dcache_addr_ok;
    logic    dcache_data_ok;
    word_t   dcache_rdata;
    logic    mem_req_r;
    addr_t   mem_raddr;
    logic    mem_addr_ok_r = 1'b0;
    logic    mem_rdy;
    logic    mem_data_ok = 1'b0;
    line_t   mem_rdata = '0;
    logic    mem_req_w;
    mem_wr_t mem_wr;
    logic    mem_addr_ok_w = 1'b0;

    test_t tests [$];
    word_t ref_mem [addr_t];     // words stored by the table
    word_t mem_model [addr_t];   // memory after writebacks
    int    seed = 32'hbc31_b5cc;
    int    errors = 0;
    int    wb_errors = 0;
    int    wb_count = 0;
    int    cycles = 0;
    int    limit = 0;

    logic    req_w_s;
    logic    req_r_s;
    logic    rdy_s;
    addr_t   raddr_s;
    addr_t   rd_addr;
    mem_wr_t wr_s;
    int      mem_wait = 0;

    l2c_top UUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic word_t pat(addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;   // untouched memory
    endfunction

    function automatic word_t expect_word(addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : pat(a);
    endfunction

    function automatic word_t model_word(addr_t a);
        return mem_model.exists(a) ? mem_model[a] : pat(a);
    endfunction

    function automatic line_t model_line(addr_t base);
        line_t l;
        for (int i = 0; i < `L2C_LINE_WORDS; i++) begin
            l[32 * i +: 32] = model_word(base + addr_t'(4 * i));
        end
        return l;
    endfunction

    // every victim line must match what the table has stored so far
    function automatic void write_back(mem_wr_t w);
        word_t got;
        addr_t a;
        wb_count++;
        for (int i = 0; i < `L2C_LINE_WORDS; i++) begin
            a   = w.addr + addr_t'(4 * i);
            got = w.line[32 * i +: 32];
            if (got !== expect_word(a)) begin
                $display("MISMATCH mem_wr.line at %h: got %h expected %h", a, got, expect_word(a));
                wb_errors++;
            end
            mem_model[a] = got;
        end
    endfunction

    function automatic void add_test(int src, int wr, addr_t a, word_t d, word_t e, int hit,
                                     addr_t ia = '0, word_t ie = '0, int wb = 0);
        tests.push_back('{src, wr, a, d, e, hit, ia, ie, wb});
    endfunction

    ////////////////////////////////////////////////////////////
    // memory model, random 0..3 cycle waits
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        req_w_s = mem_req_w;
        req_r_s = mem_req_r;
        rdy_s   = mem_rdy;
        raddr_s = mem_raddr;
        wr_s    = mem_wr;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            mem_addr_ok_w <= 1'b0;
            mem_addr_ok_r <= 1'b0;
            mem_data_ok   <= 1'b0;
        end else begin
            mem_addr_ok_w <= 1'b0;
            mem_addr_ok_r <= 1'b0;
            mem_data_ok   <= 1'b0;
            if ((req_w_s && !mem_addr_ok_w) || (req_r_s && !mem_addr_ok_r)
                    || (rdy_s && !mem_data_ok)) begin
                if (mem_wait > 0) begin
                    mem_wait <= mem_wait - 1;
                end else begin
                    mem_wait <= $random(seed) & 3;
                    if (req_w_s && !mem_addr_ok_w) begin
                        mem_addr_ok_w <= 1'b1;
                        write_back(wr_s);
                    end else if (req_r_s && !mem_addr_ok_r) begin
                        mem_addr_ok_r <= 1'b1;
                        rd_addr       <= raddr_s;
                    end else begin
                        mem_data_ok <= 1'b1;
                        mem_rdata   <= model_line(rd_addr);
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // request sequencing
    ////////////////////////////////////////////////////////////

    task automatic wait_accept(input logic dc, output int acc);
        do begin
            @(negedge clk);
            if (icache_data_ok || dcache_data_ok) begin
                $display("data_ok seen while a request was still waiting for acceptance");
                errors++;
            end
            if (dc ? icache_addr_ok : dcache_addr_ok) begin
                $display("addr_ok given to the wrong cache");
                errors++;
            end
        end while (!(dc ? dcache_addr_ok : icache_addr_ok));
        acc = cycles;
        @(posedge clk);   // accepting edge
        if (dc) begin
            dcache_req <= 1'b0;
        end else begin
            icache_req <= 1'b0;
        end
    endtask

    task automatic wait_data(input logic dc, input int acc, input int hit, input word_t exp);
        int    lat;
        word_t got;
        do begin
            @(negedge clk);
            if (dc ? icache_data_ok : dcache_data_ok) begin
                $display("data_ok given to the wrong cache");
                errors++;
            end
        end while (!(dc ? dcache_data_ok : icache_data_ok));
        lat = cycles - acc;
        got = dc ? dcache_rdata : icache_rdata;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", dc ? "dcache_rdata" : "icache_rdata",
                     got, exp);
            errors++;
        end
        if (hit == 1 && lat != 1) begin
            $display("read hit answered %0d cycles after addr_ok instead of 1", lat);
            errors++;
        end else if (hit == 0 && lat <= 1) begin
            $display("read expected to miss was answered like a hit");
            errors++;
        end
    endtask

    task automatic run_test(input int n, input test_t t);
        int acc;
        int err0;
        int wb0;
        err0 = errors + wb_errors;
        wb0  = wb_count;
        @(posedge clk);
        if (t.src != 0) begin
            dcache_req   <= 1'b1;
            dcache_wr    <= (t.wr != 0);
            dcache_addr  <= t.addr;
            dcache_wdata <= t.wdata;
        end
        if (t.src != 1) begin
            icache_req  <= 1'b1;
            icache_addr <= (t.src == 2) ? t.iaddr : t.addr;
        end
        wait_accept(t.src != 0, acc);
        if (t.wr != 0) begin
            ref_mem[t.addr] = t.wdata;   // write done at addr_ok
            @(negedge clk);               // lookup cycle of the store
            if (icache_data_ok || dcache_data_ok) begin
                $display("data_ok given for a write");
                errors++;
            end
        end else begin
            wait_data(t.src != 0, acc, t.hit, t.exp);
        end
        if (t.src == 2) begin
            wait_accept(1'b0, acc);
            wait_data(1'b0, acc, 2, t.iexp);
        end
        if (t.wb != 0 && wb_count == wb0) begin
            $display("no writeback seen for the evicted dirty line");
            errors++;
        end else if (t.wb == 0 && wb_count != wb0) begin
            $display("unexpected writeback to memory");
            errors++;
        end
        $display("test %0d addr %h: %s", n, t.addr,
                 (errors + wb_errors == err0) ? "ok" : "failed");
    endtask

    task automatic check_reset_idle();
        int err0;
        err0 = errors;
        repeat (3) begin
            @(negedge clk);
            if ({icache_addr_ok, icache_data_ok, dcache_addr_ok, dcache_data_ok,
                 mem_req_r, mem_req_w, mem_rdy} !== 7'b0) begin
                $display("handshake or memory request active after reset with nothing pending");
                errors++;
            end
        end
        $display("test 0 reset idle: %s", (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        rstn         = 1'b0;
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;

        // read miss, then hits on the same line
        add_test(1, 0, 32'h0001_0018, 0, pat(32'h0001_0018), 0);
        add_test(1, 0, 32'h0001_0018, 0, pat(32'h0001_0018), 1);
        add_test(0, 0, 32'h0001_001c, 0, pat(32'h0001_001c), 1);
        // write hit seen by both caches
        add_test(1, 0, 32'h0002_0024, 0, pat(32'h0002_0024), 0);
        add_test(1, 1, 32'h0002_0024, 32'hdead_beef, 32'hdead_beef, 2);
        add_test(1, 0, 32'h0002_0024, 0, 32'hdead_beef, 1);
        add_test(0, 0, 32'h0002_0024, 0, 32'hdead_beef, 1);
        // five lines in set 5, the dirty first one gets evicted
        add_test(1, 1, 32'h0000_1050, 32'hcafe_0001, 32'hcafe_0001, 2);
        add_test(1, 0, 32'h0000_2054, 0, pat(32'h0000_2054), 0);
        add_test(0, 0, 32'h0000_3058, 0, pat(32'h0000_3058), 0);
        add_test(1, 0, 32'h0000_405c, 0, pat(32'h0000_405c), 0);
        add_test(1, 0, 32'h0000_5050, 0, pat(32'h0000_5050), 0, '0, '0, 1);
        add_test(1, 0, 32'h0000_1050, 0, 32'hcafe_0001, 0);
        add_test(0, 0, 32'h0000_1054, 0, pat(32'h0000_1054), 1);
        // both caches in the same cycle
        add_test(2, 0, 32'h0003_0030, 0, pat(32'h0003_0030), 0,
                 32'h0004_0034, pat(32'h0004_0034));
        add_test(2, 0, 32'h0003_0030, 0, pat(32'h0003_0030), 1,
                 32'h0004_0038, pat(32'h0004_0038));
        // write allocate into a fresh line
        add_test(1, 1, 32'h0006_0068, 32'h1234_5678, 32'h1234_5678, 2);
        add_test(1, 0, 32'h0006_0064, 0, pat(32'h0006_0064), 1);
        add_test(1, 0, 32'h0006_0068, 0, 32'h1234_5678, 1);
        add_test(0, 0, 32'h0006_006c, 0, pat(32'h0006_006c), 1);

        limit = (tests.size() + 1) * 40;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        check_reset_idle();
        foreach (tests[i]) begin
            run_test(i + 1, tests[i]);
        end
        repeat (2) @(posedge clk);

        errors = errors + wb_errors;
        $display("%0d tests run, %0d errors", tests.size() + 1, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
